/* design/icache_pkg.sv */
/*
 * Instruction cache subsystem shared definitions.
 * Address layout is tag | index | offset, with bit 2 picking the word.
 */
`default_nettype none

package icache_pkg;

	localparam int ADDR_W     = 16;             // byte address.
	localparam int DATA_W     = 32;             // response word.
	localparam int LINE_W     = 64;             // two words per line.
	localparam int OFS_W      = 3;
	localparam int IDX_W      = 4;
	localparam int TAG_W      = 9;
	localparam int LADDR_W    = TAG_W + IDX_W;  // line address.
	localparam int SETS       = 1 << IDX_W;
	localparam int VC_ENTRIES = 4;
	localparam int VC_PTR_W   = 2;
	localparam int WORD_BIT   = 2;              // word select within a line.

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// address field helpers
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	function automatic logic [LADDR_W-1:0] addr_line(input logic [ADDR_W-1:0] a);
		return a[ADDR_W-1:OFS_W];
	endfunction

	function automatic logic [IDX_W-1:0] laddr_idx(input logic [LADDR_W-1:0] la);
		return la[IDX_W-1:0];
	endfunction

	function automatic logic [TAG_W-1:0] laddr_tag(input logic [LADDR_W-1:0] la);
		return la[LADDR_W-1:IDX_W];
	endfunction

	// upper word when hi is set.
	function automatic logic [DATA_W-1:0] word_sel(input logic [LINE_W-1:0] line,
			input logic hi);
		return hi ? line[LINE_W-1:DATA_W] : line[DATA_W-1:0];
	endfunction

endpackage

`default_nettype wire

/* design/icache_if.sv */
/*
 * Internal interfaces of the instruction cache.
 * victim_if links the front stage to the victim store,
 * stage_if links the front stage to the response stage.
 */
`default_nettype none

interface victim_if import icache_pkg::*; ();
	logic                wr_en;
	logic [TAG_W-1:0]    wr_tag;
	logic [IDX_W-1:0]    wr_idx;
	logic [LINE_W-1:0]   wr_line;
	logic [TAG_W-1:0]    rd_tag;   // lookup key.
	logic [IDX_W-1:0]    rd_idx;
	logic                rd_hit;
	logic [LINE_W-1:0]   rd_line;
	logic [TAG_W-1:0]    pf_tag;   // probe key.
	logic [IDX_W-1:0]    pf_idx;
	logic                pf_hit;

	modport owner (output wr_en, wr_tag, wr_idx, wr_line, rd_tag, rd_idx, pf_tag, pf_idx,
		input rd_hit, rd_line, pf_hit);
	modport store (input wr_en, wr_tag, wr_idx, wr_line, rd_tag, rd_idx, pf_tag, pf_idx,
		output rd_hit, rd_line, pf_hit);
endinterface

interface stage_if import icache_pkg::*; ();
	// front to back.
	logic                valid;
	logic [ADDR_W-1:0]   addr;
	logic                arr_hit;
	logic                vc_hit;
	logic [LINE_W-1:0]   line;
	// back to front.
	logic                fill_en;
	logic [LADDR_W-1:0]  fill_addr;
	logic [LINE_W-1:0]   fill_line;
	logic                stall;

	modport front (output valid, addr, arr_hit, vc_hit, line,
		input fill_en, fill_addr, fill_line, stall);
	modport back (input valid, addr, arr_hit, vc_hit, line,
		output fill_en, fill_addr, fill_line, stall);
endinterface

`default_nettype wire

/* design/victim_cache.sv */
/*
 * Four entry fully associative victim store.
 * Round robin writes, one lookup CAM port and one probe CAM port.
 */
`default_nettype none

module victim_cache import icache_pkg::*; (
	input  logic     clk,
	input  logic     rst,
	victim_if.store  vc
);

	logic [LINE_W-1:0]      line_r [VC_ENTRIES];
	logic [TAG_W-1:0]       tag_r  [VC_ENTRIES];
	logic [IDX_W-1:0]       idx_r  [VC_ENTRIES];
	logic [VC_ENTRIES-1:0]  vld_r;
	logic [VC_PTR_W-1:0]    wr_ptr_r;
	logic                   key_clash;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// CAM compares
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_comb begin
		vc.rd_hit  = 1'b0;
		vc.rd_line = '0;
		vc.pf_hit  = 1'b0;
		for (int i = 0; i < VC_ENTRIES; i++) begin
			if (vld_r[i] && {tag_r[i], idx_r[i]} == {vc.rd_tag, vc.rd_idx}) begin
				vc.rd_hit  = 1'b1;
				vc.rd_line = line_r[i];
			end
			if (vld_r[i] && {tag_r[i], idx_r[i]} == {vc.pf_tag, vc.pf_idx})
				vc.pf_hit = 1'b1;
		end
	end

	// duplicates are allowed, but they must agree.
	always_comb begin
		key_clash = 1'b0;
		for (int i = 0; i < VC_ENTRIES; i++) begin
			for (int j = i + 1; j < VC_ENTRIES; j++) begin
				if (vld_r[i] && vld_r[j] && tag_r[i] == tag_r[j] && idx_r[i] == idx_r[j] &&
						line_r[i] != line_r[j])
					key_clash = 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			vld_r    <= '0;
			wr_ptr_r <= '0;
		end else if (vc.wr_en) begin
			vld_r[wr_ptr_r] <= 1'b1;
			wr_ptr_r        <= wr_ptr_r + VC_PTR_W'(1);   // wraps after the last entry.
		end
	end

	always_ff @(posedge clk) begin
		if (vc.wr_en) begin
			line_r[wr_ptr_r] <= vc.wr_line;
			tag_r[wr_ptr_r]  <= vc.wr_tag;
			idx_r[wr_ptr_r]  <= vc.wr_idx;
		end
	end

	a_no_key_clash: assert property (@(posedge clk) disable iff (rst) !key_clash)
		else $error("ERR victim entries disagree, vld_r=%h", vld_r);

endmodule

`default_nettype wire

/* design/icache_lookup.sv */
/*
 * Instruction cache front stage.
 * Registers the fetch, holds the direct mapped array and compares tags.
 * Fills from the back stage overwrite a set and push the old line out
 * to the victim cache.
 */
`default_nettype none

module icache_lookup import icache_pkg::*; (
	input  logic                clk,
	input  logic                rst,
	input  logic                req_valid_i,
	input  logic [ADDR_W-1:0]   req_addr_i,
	output logic                req_ready_o,
	input  logic [LADDR_W-1:0]  probe_addr_i,
	output logic                probe_hit_o,
	stage_if.front              st,
	victim_if.owner             vc
);

	logic [TAG_W-1:0]   tag_arr  [SETS];
	logic [LINE_W-1:0]  data_arr [SETS];
	logic [SETS-1:0]    vld_arr;

	logic               req_v_r;
	logic [ADDR_W-1:0]  req_addr_r;
	logic               accept;

	logic [IDX_W-1:0]   cur_idx, fill_idx, pb_idx;
	logic [TAG_W-1:0]   cur_tag, fill_tag, pb_tag;
	logic               arr_match;

	assign req_ready_o = !st.stall;
	assign accept      = req_valid_i && req_ready_o;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// request register
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clk) begin
		if (rst)
			req_v_r <= 1'b0;
		else
			req_v_r <= accept;   // a stalled request is always consumed by the back stage.
	end

	always_ff @(posedge clk) begin
		if (accept)
			req_addr_r <= req_addr_i;
	end

	// tag compare.
	assign cur_idx   = laddr_idx(addr_line(req_addr_r));
	assign cur_tag   = laddr_tag(addr_line(req_addr_r));
	assign arr_match = vld_arr[cur_idx] && (tag_arr[cur_idx] == cur_tag);

	assign st.valid   = req_v_r;
	assign st.addr    = req_addr_r;
	assign st.arr_hit = req_v_r && arr_match;
	assign st.vc_hit  = req_v_r && vc.rd_hit;
	assign st.line    = arr_match ? data_arr[cur_idx] : vc.rd_line;

	assign vc.rd_tag = cur_tag;
	assign vc.rd_idx = cur_idx;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// fill and eviction
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	assign fill_idx = laddr_idx(st.fill_addr);
	assign fill_tag = laddr_tag(st.fill_addr);

	assign vc.wr_en   = st.fill_en && vld_arr[fill_idx];  // only a valid line is worth keeping.
	assign vc.wr_tag  = tag_arr[fill_idx];
	assign vc.wr_idx  = fill_idx;
	assign vc.wr_line = data_arr[fill_idx];

	always_ff @(posedge clk) begin
		if (rst)
			vld_arr <= '0;
		else if (st.fill_en)
			vld_arr[fill_idx] <= 1'b1;
	end

	always_ff @(posedge clk) begin
		if (st.fill_en) begin
			tag_arr[fill_idx]  <= fill_tag;
			data_arr[fill_idx] <= st.fill_line;
		end
	end

	// probe looks at the array here and at the victim store through the second CAM port.
	assign pb_idx      = laddr_idx(probe_addr_i);
	assign pb_tag      = laddr_tag(probe_addr_i);
	assign vc.pf_idx   = pb_idx;
	assign vc.pf_tag   = pb_tag;
	assign probe_hit_o = (vld_arr[pb_idx] && (tag_arr[pb_idx] == pb_tag)) || vc.pf_hit;

	// fills only land while the front register is blocked.
	a_fill_no_accept: assert property (@(posedge clk) disable iff (rst)
		st.fill_en |-> !accept)
		else $error("ERR fill_en with req accept, req_addr_i=%h", req_addr_i);

endmodule

`default_nettype wire

/* design/icache_resp.sv */
/*
 * Instruction cache response stage.
 * Answers hits in one cycle, swaps victim hits back into the array
 * and runs the memory request on a miss.
 */
`default_nettype none

module icache_resp import icache_pkg::*; (
	input  logic                clk,
	input  logic                rst,
	stage_if.back               st,
	output logic                resp_valid_o,
	output logic [DATA_W-1:0]   resp_data_o,
	output logic                mem_req_o,
	output logic [LADDR_W-1:0]  mem_addr_o,
	input  logic                mem_valid_i,
	input  logic [LINE_W-1:0]   mem_data_i
);

	typedef enum logic {ST_IDLE, ST_WAIT} state_t;

	state_t               state_r;
	logic                 resp_valid_r;
	logic [DATA_W-1:0]    resp_data_r;
	logic [LADDR_W-1:0]   miss_laddr_r;
	logic                 miss_word_r;
	logic                 hit_now, miss_now, mem_done;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// decode of the front stage result
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_comb begin
		hit_now  = (state_r == ST_IDLE) && st.valid && (st.arr_hit || st.vc_hit);
		miss_now = (state_r == ST_IDLE) && st.valid && !st.arr_hit && !st.vc_hit;
		mem_done = (state_r == ST_WAIT) && mem_valid_i;
	end

	// anything but an array hit blocks the front for at least a cycle.
	assign st.stall = (state_r == ST_WAIT) || (st.valid && !st.arr_hit);

	always_comb begin
		st.fill_en   = 1'b0;
		st.fill_addr = addr_line(st.addr);
		st.fill_line = st.line;
		if (mem_done) begin
			st.fill_en   = 1'b1;
			st.fill_addr = miss_laddr_r;
			st.fill_line = mem_data_i;
		end else if (hit_now && !st.arr_hit) begin
			st.fill_en = 1'b1;   // swap the victim line back in.
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state_r      <= ST_IDLE;
			resp_valid_r <= 1'b0;
		end else begin
			resp_valid_r <= hit_now || mem_done;
			case (state_r)
				ST_IDLE: if (miss_now) state_r <= ST_WAIT;
				ST_WAIT: if (mem_valid_i) state_r <= ST_IDLE;
				default: state_r <= ST_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (miss_now) begin
			miss_laddr_r <= addr_line(st.addr);
			miss_word_r  <= st.addr[WORD_BIT];
		end
		if (hit_now)
			resp_data_r <= word_sel(st.line, st.addr[WORD_BIT]);
		else if (mem_done)
			resp_data_r <= word_sel(mem_data_i, miss_word_r);
	end

	assign resp_valid_o = resp_valid_r;
	assign resp_data_o  = resp_data_r;
	assign mem_req_o    = (state_r == ST_WAIT);   // request level is the wait state.
	assign mem_addr_o   = miss_laddr_r;

	a_mem_req_hold: assert property (@(posedge clk) disable iff (rst)
		mem_req_o && !mem_valid_i |=> mem_req_o && $stable(mem_addr_o))
		else $error("ERR mem_req_o=%h mem_addr_o=%h not held", mem_req_o, mem_addr_o);

	a_no_resp_in_wait: assert property (@(posedge clk) disable iff (rst)
		!(resp_valid_o && mem_req_o))
		else $error("ERR resp_valid_o during wait, mem_addr_o=%h", mem_addr_o);

endmodule

`default_nettype wire

/* design/icache_top.sv */
/*
 * Instruction cache subsystem top.
 * Front stage with its victim store, then the response stage.
 */
`default_nettype none

module icache_top import icache_pkg::*; (
	input  logic                clk,
	input  logic                rst,
	// fetch request.
	input  logic                req_valid_i,
	input  logic [ADDR_W-1:0]   req_addr_i,
	output logic                req_ready_o,
	// response.
	output logic                resp_valid_o,
	output logic [DATA_W-1:0]   resp_data_o,
	// memory side.
	output logic                mem_req_o,
	output logic [LADDR_W-1:0]  mem_addr_o,
	input  logic                mem_valid_i,
	input  logic [LINE_W-1:0]   mem_data_i,
	// residency probe.
	input  logic [LADDR_W-1:0]  probe_addr_i,
	output logic                probe_hit_o
);

	victim_if vc_if ();
	stage_if  st_if ();

	icache_lookup lookup_i (
		.clk          (clk),
		.rst          (rst),
		.req_valid_i  (req_valid_i),
		.req_addr_i   (req_addr_i),
		.req_ready_o  (req_ready_o),
		.probe_addr_i (probe_addr_i),
		.probe_hit_o  (probe_hit_o),
		.st           (st_if.front),
		.vc           (vc_if.owner)
	);

	victim_cache victim_i (
		.clk (clk),
		.rst (rst),
		.vc  (vc_if.store)
	);

	icache_resp resp_i (
		.clk          (clk),
		.rst          (rst),
		.st           (st_if.back),
		.resp_valid_o (resp_valid_o),
		.resp_data_o  (resp_data_o),
		.mem_req_o    (mem_req_o),
		.mem_addr_o   (mem_addr_o),
		.mem_valid_i  (mem_valid_i),
		.mem_data_i   (mem_data_i)
	);

endmodule

`default_nettype wire

/* bench/icache_mem_model.sv */
/*
 * Memory responder for the instruction cache.
 * Answers each line request after 1 to 8 cycles with data derived
 * from the word addresses of the line.
 */
`default_nettype none

module icache_mem_model import icache_pkg::*; (
	input  logic                clk,
	input  logic                rst,
	input  logic                mem_req_i,
	input  logic [LADDR_W-1:0]  mem_addr_i,
	output logic                mem_valid_o,
	output logic [LINE_W-1:0]   mem_data_o
);

	int unsigned  wait_n;
	logic         busy;

	// word value is its byte address below and the inverse above.
	function automatic logic [DATA_W-1:0] word_at(input logic [LADDR_W-1:0] la,
			input logic hi);
		logic [ADDR_W-1:0] wa;
		wa = {la, hi, 2'b00};
		return {~wa, wa};
	endfunction

	initial begin
		mem_valid_o = 1'b0;
		mem_data_o  = '0;
		busy        = 1'b0;
		wait_n      = 0;
		forever begin
			@(posedge clk);
			#10;
			if (rst || mem_valid_o) begin
				mem_valid_o = 1'b0;    // taken by the cache at this edge.
				busy        = 1'b0;
			end else if (busy) begin
				wait_n--;
				if (wait_n == 0) begin
					mem_valid_o = 1'b1;
					mem_data_o  = {word_at(mem_addr_i, 1'b1), word_at(mem_addr_i, 1'b0)};
				end
			end else if (mem_req_i) begin
				busy   = 1'b1;
				wait_n = 1 + ($urandom % 8);
			end
		end
	end

endmodule

`default_nettype wire

/* bench/icache_tb.sv */
/*
 * Instruction cache subsystem testbench.
 * Runs fetch sequences and probes against a residency model,
 * with concurrent assertions on responses, memory requests and probes.
 */
`default_nettype none

module icache_tb import icache_pkg::*; ();

	logic                clk;
	logic                rst;
	logic                req_valid_i;
	logic [ADDR_W-1:0]   req_addr_i;
	logic                req_ready_o;
	logic                resp_valid_o;
	logic [DATA_W-1:0]   resp_data_o;
	logic                mem_req_o;
	logic [LADDR_W-1:0]  mem_addr_o;
	logic                mem_valid_i;
	logic [LINE_W-1:0]   mem_data_i;
	logic [LADDR_W-1:0]  probe_addr_i;
	logic                probe_hit_o;

	// residency model, one line per set plus a round robin victim list.
	logic [TAG_W-1:0]       m_atag [SETS];
	logic [SETS-1:0]        m_avld;
	logic [LADDR_W-1:0]     m_vkey [VC_ENTRIES];
	logic [VC_ENTRIES-1:0]  m_vvld;
	logic [VC_PTR_W-1:0]    m_vptr;
	logic                   swap_pend;
	logic [LADDR_W-1:0]     swap_la, ins_la, acc_la, chosen_la;
	logic [ADDR_W-1:0]      pend [4];       // accepted fetches awaiting a response.
	logic [2:0]             wr_n, rd_n;
	logic                   acc, in_arr, in_vc, ins_en, probe_exp;
	logic [DATA_W-1:0]      exp_data;

	icache_top dut_i (.*);

	icache_mem_model mem_i (
		.clk         (clk),
		.rst         (rst),
		.mem_req_i   (mem_req_o),
		.mem_addr_i  (mem_addr_o),
		.mem_valid_o (mem_valid_i),
		.mem_data_o  (mem_data_i)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	task automatic report_fail(input string what);
		$display("%s", what);
		$display("Done: errors found");
		$fatal(1, "stopped at the first failing check");
	endtask

	// low half is the word's byte address, high half its inverse.
	function automatic logic [DATA_W-1:0] expect_word(input logic [ADDR_W-1:0] a);
		logic [ADDR_W-1:0] wa;
		wa = {a[ADDR_W-1:2], 2'b00};
		return {~wa, wa};
	endfunction

	function automatic logic in_array(input logic [LADDR_W-1:0] la);
		return m_avld[la[IDX_W-1:0]] && (m_atag[la[IDX_W-1:0]] == la[LADDR_W-1:IDX_W]);
	endfunction

	function automatic logic in_victim(input logic [LADDR_W-1:0] la);
		logic hit;
		hit = 1'b0;
		for (int i = 0; i < VC_ENTRIES; i++)
			if (m_vvld[i] && m_vkey[i] == la)
				hit = 1'b1;
		return hit;
	endfunction

	always_comb begin
		acc       = req_valid_i && req_ready_o;
		acc_la    = req_addr_i[ADDR_W-1:OFS_W];
		in_arr    = in_array(acc_la);
		in_vc     = in_victim(acc_la);
		probe_exp = in_array(probe_addr_i) || in_victim(probe_addr_i);
		ins_en    = (mem_req_o && mem_valid_i) || swap_pend;   // an array fill.
		ins_la    = mem_req_o ? mem_addr_o : swap_la;
		exp_data  = expect_word(pend[rd_n[1:0]]);
	end

	always @(posedge clk) begin
		if (rst) begin
			m_avld    <= '0;
			m_vvld    <= '0;
			m_vptr    <= '0;
			swap_pend <= 1'b0;
			wr_n      <= '0;
			rd_n      <= '0;
		end else begin
			swap_pend <= acc && in_vc && !in_arr;   // swap lands one edge later.
			swap_la   <= acc_la;
			if (ins_en && m_avld[ins_la[IDX_W-1:0]]) begin
				m_vkey[m_vptr] <= {m_atag[ins_la[IDX_W-1:0]], ins_la[IDX_W-1:0]};
				m_vvld[m_vptr] <= 1'b1;
				m_vptr         <= m_vptr + 2'd1;
			end
			if (ins_en) begin
				m_avld[ins_la[IDX_W-1:0]] <= 1'b1;
				m_atag[ins_la[IDX_W-1:0]] <= ins_la[LADDR_W-1:IDX_W];
			end
			if (acc) begin
				pend[wr_n[1:0]] <= req_addr_i;
				wr_n            <= wr_n + 3'd1;
			end
			if (resp_valid_o)
				rd_n <= rd_n + 3'd1;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// checks
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	a_reset_state: assert property (@(posedge clk)
		$fell(rst) |-> req_ready_o && !resp_valid_o && !mem_req_o)
		else report_fail($sformatf("ERR after reset req_ready_o=%h resp_valid_o=%h mem_req_o=%h",
			$sampled(req_ready_o), $sampled(resp_valid_o), $sampled(mem_req_o)));

	a_hit_resp: assert property (@(posedge clk) disable iff (rst)
		$past(acc && (in_arr || in_vc), 2) |-> resp_valid_o && !mem_req_o)
		else report_fail($sformatf("ERR resp_valid_o=%h mem_req_o=%h two cycles after a hit",
			$sampled(resp_valid_o), $sampled(mem_req_o)));

	a_victim_stall: assert property (@(posedge clk) disable iff (rst)
		$past(acc && in_vc && !in_arr, 2) |-> req_ready_o && !$past(req_ready_o))
		else report_fail("req_ready_o did not drop for exactly one cycle on a victim hit");

	a_miss_req: assert property (@(posedge clk) disable iff (rst)
		$past(acc && !in_arr && !in_vc, 2) |-> mem_req_o && mem_addr_o == $past(acc_la, 2))
		else report_fail($sformatf("ERR mem_req_o=%h mem_addr_o got %h exp %h",
			$sampled(mem_req_o), $sampled(mem_addr_o), $past(acc_la, 2)));

	a_req_hold: assert property (@(posedge clk) disable iff (rst)
		mem_req_o && !mem_valid_i |=> mem_req_o && $stable(mem_addr_o))
		else report_fail("memory request dropped or changed address before mem_valid_i");

	a_miss_done: assert property (@(posedge clk) disable iff (rst)
		$past(mem_req_o && mem_valid_i) |-> resp_valid_o && req_ready_o && !mem_req_o)
		else report_fail($sformatf("ERR resp_valid_o=%h req_ready_o=%h after memory data",
			$sampled(resp_valid_o), $sampled(req_ready_o)));

	a_resp_owed: assert property (@(posedge clk) disable iff (rst)
		resp_valid_o |-> rd_n != wr_n)
		else report_fail("a response arrived with no fetch outstanding");

	a_resp_data: assert property (@(posedge clk) disable iff (rst)
		resp_valid_o |-> resp_data_o == exp_data)
		else report_fail($sformatf("ERR resp_data_o got %h exp %h",
			$sampled(resp_data_o), $sampled(exp_data)));

	a_probe: assert property (@(posedge clk) disable iff (rst) probe_hit_o == probe_exp)
		else report_fail($sformatf("ERR probe_hit_o got %h exp %h for probe_addr_i %h",
			$sampled(probe_hit_o), $sampled(probe_exp), $sampled(probe_addr_i)));

	// present one fetch and hold it through the accepting edge.
	task automatic fetch(input logic [ADDR_W-1:0] a);
		int n;
		req_valid_i = 1'b1;
		req_addr_i  = a;
		n = 0;
		while (!req_ready_o) begin
			if (n == 40)
				report_fail($sformatf("fetch of %h was not accepted within 40 cycles", a));
			else begin
				@(posedge clk);
				#10;
				n++;
			end
		end
		@(posedge clk);
		#10;
		req_valid_i = 1'b0;
	endtask

	initial begin : probe_drive
		probe_addr_i = '0;
		forever begin
			@(posedge clk);
			#10;
			case ($urandom % 3)
				0: probe_addr_i = LADDR_W'($urandom);
				1: probe_addr_i = LADDR_W'($urandom % 128);   // region of the random fetches.
				default: probe_addr_i = chosen_la;
			endcase
		end
	end

	initial begin : stimulus
		int n;
		void'($urandom(8));
		rst         = 1'b1;
		req_valid_i = 1'b0;
		req_addr_i  = '0;
		chosen_la   = '0;
		repeat (5) @(posedge clk);
		#10;
		rst = 1'b0;
		// cold miss, then back to back hits on that line.
		fetch(16'h0124);
		chosen_la = 13'h0024;
		fetch(16'h0120);
		fetch(16'h0124);
		fetch(16'h0120);
		repeat (40) fetch(ADDR_W'(($urandom % 256) * 4));
		// lines A and B share set 2, so A comes back from the victim cache.
		fetch(16'h1014);
		fetch(16'h2010);
		chosen_la = 13'h0202;
		fetch(16'h1010);
		// six tags in set 5 push the first one out of the victim cache.
		for (int i = 0; i < 6; i++)
			fetch(ADDR_W'((8'h30 + i) << 7) | 16'h0028);
		chosen_la = 13'h0305;
		fetch(16'h1828);
		n = 0;
		while (rd_n != wr_n) begin
			if (n == 40)
				report_fail("responses still outstanding at the end of the run");
			else begin
				@(posedge clk);
				#10;
				n++;
			end
		end
		repeat (2) @(posedge clk);
		$display("Done: no errors");
		$finish;
	end

endmodule

`default_nettype wire

/* icache_sub.f */
design/icache_pkg.sv
design/icache_if.sv
design/victim_cache.sv
design/icache_lookup.sv
design/icache_resp.sv
design/icache_top.sv
bench/icache_mem_model.sv
bench/icache_tb.sv

/* Makefile */
# Verilator flow for the instruction cache subsystem.
VERILATOR ?= verilator
TOP       ?= icache_tb
FILELIST  ?= icache_sub.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?=

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary --timing --assert $(VFLAGS) -f $(FILELIST) \
		--top-module $(TOP) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "Done: no errors" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
